// File: flist.f
+incdir+rtl
rtl/csi2_rx_pkg.sv
rtl/csi2_hamming_dec.sv
rtl/csi2_crc16_chk.sv
rtl/csi2_pkt_ctrl.sv
rtl/csi2_sts_port.sv
rtl/csi2_rx_top.sv
test/csi2_rx_assert.sv
test/tb_csi2_rx.sv

// File: rtl/csi2_crc16_chk.sv
`include "csi2_rx_consts.svh"

module csi2_crc16_chk
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               start_i,
  input  logic               word_valid_i,
  input  csi2_rx_pkg::word_t word_i,
  input  logic               check_i,
  input  csi2_rx_pkg::crc_t  crc_rx_i,
  output logic               crc_err_o
);

  import csi2_rx_pkg::*;

  crc_t crc_q;

  // four bytes per call, low byte first, each byte lsb first
  function automatic crc_t crc_fold(crc_t crc_in, word_t w);
    crc_t c;
    c = crc_in;
    for (int b = 0; b < 4; b++)
    begin
      c = c ^ crc_t'(w[8*b +: 8]);
      for (int i = 0; i < 8; i++)
      begin
        if (c[0])
          c = (c >> 1) ^ `CSI2_CRC_POLY;
        else
          c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      crc_q <= `CSI2_CRC_INIT;
    else if (start_i)
      crc_q <= `CSI2_CRC_INIT;                // new long packet
    else if (word_valid_i)
      crc_q <= crc_fold(crc_q, word_i);
  end

  // verdict held until the next packet starts
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      crc_err_o <= 1'b0;
    else if (start_i)
      crc_err_o <= 1'b0;
    else if (check_i)
      crc_err_o <= (crc_q != crc_rx_i);
  end

endmodule

// File: rtl/csi2_hamming_dec.sv
`include "csi2_rx_consts.svh"

module csi2_hamming_dec
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  input  csi2_rx_pkg::word_t data_i,
  input  logic               pkt_done_i,
  output logic               valid_o,
  output csi2_rx_pkg::word_t data_o,
  output logic               error_o,
  output logic               error_corrected_o
);

  import csi2_rx_pkg::*;

  // data bits feeding each ecc bit, ecc[5] leftmost
  localparam logic [5:0][23:0] ECC_MASK = {24'hEFFC00, 24'hDF03F0, 24'hB8E38E,
                                           24'h749A6D, 24'hF2555B, 24'hF12CB7};

  ecc_t    ecc_calc;
  ecc_t    syndrome;
  word_t   data_d;
  logic    valid_d;
  bitpos_t pos_d;       // registered syndrome lookup
  logic    syn_nz_d;
  logic    syn_one_d;   // single ecc bit in error
  logic    hdr_seen;    // header of current packet already passed
  logic    hdr_valid;
  logic    fix_bit;
  word_t   flip_mask;

  // --------------------------------------------------------------------------
  // stage 1: syndrome and lookup
  // --------------------------------------------------------------------------
  always_comb
  begin
    for (int k = 0; k < 6; k++)
      ecc_calc[k] = ^(data_i[`CSI2_HDR_MSB:0] & ECC_MASK[k]);
  end

  assign syndrome = ecc_calc ^ data_i[`CSI2_ECC_MSB:`CSI2_ECC_LSB];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      valid_d   <= 1'b0;
      pos_d     <= `CSI2_NO_POS;
      syn_nz_d  <= 1'b0;
      syn_one_d <= 1'b0;
    end
    else
    begin
      valid_d   <= valid_i;
      pos_d     <= syndrome_pos(syndrome);
      syn_nz_d  <= (syndrome != '0);
      syn_one_d <= $onehot(syndrome);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pkt_done_i)
      data_d <= '0;
    else
      data_d <= data_i;
  end

  // first valid word after a packet end is the header
  assign hdr_valid = valid_d && !hdr_seen && !pkt_done_i;
  assign fix_bit   = hdr_valid && (pos_d != `CSI2_NO_POS);
  assign flip_mask = fix_bit ? (word_t'(1) << pos_d) : '0;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      hdr_seen <= 1'b0;
    else if (pkt_done_i)
      hdr_seen <= 1'b0;
    else if (hdr_valid)
      hdr_seen <= 1'b1;
  end

  // --------------------------------------------------------------------------
  // stage 2: corrected word and flags
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      valid_o <= 1'b0;
    else
      valid_o <= valid_d;
  end

  always_ff @(posedge clk_i)
  begin
    data_o <= data_d ^ flip_mask;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else if (pkt_done_i)
    begin
      error_o           <= 1'b0;
      error_corrected_o <= 1'b0;
    end
    else if (hdr_valid && syn_nz_d)
    begin
      error_o           <= 1'b1;
      error_corrected_o <= fix_bit || syn_one_d;  // data bit or ecc bit
    end
  end

endmodule

// File: rtl/csi2_pkt_ctrl.sv
`include "csi2_rx_consts.svh"

module csi2_pkt_ctrl
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   hd_valid_i,
  input  csi2_rx_pkg::word_t     hd_data_i,
  input  logic                   hd_err_i,
  input  logic                   hd_corr_i,
  input  logic                   crc_err_i,
  output logic                   pkt_done_o,
  output logic                   crc_start_o,
  output logic                   crc_word_valid_o,
  output csi2_rx_pkg::word_t     crc_word_o,
  output logic                   crc_check_o,
  output csi2_rx_pkg::crc_t      crc_rx_o,
  output logic                   pld_valid_o,
  output csi2_rx_pkg::word_t     pld_data_o,
  output logic                   pld_last_o,
  output logic                   rec_valid_o,
  output csi2_rx_pkg::data_id_t  rec_data_id_o,
  output csi2_rx_pkg::wcount_t   rec_wcount_o,
  output logic                   rec_ecc_err_o,
  output logic                   rec_ecc_corr_o,
  output logic                   rec_crc_err_o
);

  import csi2_rx_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_nx;
  wcount_t     cnt_q;        // payload words still expected
  logic        crc_seen_q;   // crc word taken, verdict arrives now
  data_id_t    hdr_id;
  wcount_t     hdr_wc;
  wcount_t     hdr_words;
  logic        hdr_bad;
  logic        hdr_short;
  logic        hdr_take;
  logic        pld_take;
  logic        pld_last;
  logic        crc_take;
  logic        crc_done;

  assign hdr_id    = hd_data_i[`CSI2_ID_MSB:`CSI2_ID_LSB];
  assign hdr_wc    = hd_data_i[`CSI2_WC_MSB:`CSI2_WC_LSB];
  assign hdr_words = hdr_wc >> 2;                     // byte count to words
  assign hdr_bad   = hd_err_i && !hd_corr_i;
  assign hdr_short = (hdr_id <= `CSI2_SHORT_ID_MAX);

  assign hdr_take  = (state_q == IDLE) && hd_valid_i;
  assign pld_take  = (state_q == PAYLOAD) && hd_valid_i;
  assign pld_last  = pld_take && (cnt_q == wcount_t'(1));
  assign crc_take  = (state_q == CRC_WAIT) && hd_valid_i && !crc_seen_q;
  assign crc_done  = (state_q == CRC_WAIT) && crc_seen_q;

  // --------------------------------------------------------------------------
  // state machine
  // --------------------------------------------------------------------------
  always_comb
  begin
    state_nx = state_q;
    case (state_q)
      IDLE:
        if (hd_valid_i)
        begin
          if (hdr_bad)
            state_nx = DROP;
          else if (hdr_short)
            state_nx = REPORT;
          else if (hdr_words == '0)
            state_nx = CRC_WAIT;                      // crc word follows header
          else
            state_nx = PAYLOAD;
        end
      PAYLOAD:  if (pld_last) state_nx = CRC_WAIT;
      CRC_WAIT: if (crc_done) state_nx = REPORT;
      REPORT:   state_nx = IDLE;
      DROP:     if (!hd_valid_i) state_nx = IDLE;   // rest of bad packet gone
      default:  state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      crc_seen_q  <= 1'b0;
      pkt_done_o  <= 1'b0;
      rec_valid_o <= 1'b0;
      pld_valid_o <= 1'b0;
      pld_last_o  <= 1'b0;
    end
    else
    begin
      state_q     <= state_nx;
      crc_seen_q  <= crc_take;
      pkt_done_o  <= (state_nx == DROP) || (hdr_take && hdr_short && !hdr_bad) || crc_take;
      rec_valid_o <= (hdr_take && (hdr_bad || hdr_short)) || crc_done;
      pld_valid_o <= pld_take;
      pld_last_o  <= pld_last;
      if (hdr_take)
        cnt_q <= hdr_words;
      else if (pld_take)
        cnt_q <= cnt_q - wcount_t'(1);
    end
  end

  // --------------------------------------------------------------------------
  // payload and record fields
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    pld_data_o <= hd_data_i;
    if (hdr_take)
    begin
      rec_data_id_o  <= hdr_id;
      rec_wcount_o   <= hdr_wc;
      rec_ecc_err_o  <= hd_err_i;
      rec_ecc_corr_o <= hd_corr_i;
      rec_crc_err_o  <= 1'b0;        // short and dropped packets
    end
    else if (crc_done)
      rec_crc_err_o  <= crc_err_i;
  end

  // checker side
  assign crc_start_o      = hdr_take && !hdr_bad && !hdr_short;
  assign crc_word_valid_o = pld_take;
  assign crc_word_o       = hd_data_i;
  assign crc_check_o      = crc_take;
  assign crc_rx_o         = hd_data_i[`CSI2_CRC_MSB:0];

endmodule

// File: rtl/csi2_rx_consts.svh
`ifndef CSI2_RX_CONSTS_SVH
`define CSI2_RX_CONSTS_SVH

// header word layout
`define CSI2_ID_MSB        7
`define CSI2_ID_LSB        0
`define CSI2_WC_MSB        23
`define CSI2_WC_LSB        8
`define CSI2_ECC_MSB       29
`define CSI2_ECC_LSB       24
`define CSI2_HDR_MSB       23     // top data bit covered by the ecc
`define CSI2_CRC_MSB       15     // crc sits in the low half of its word

`define CSI2_NO_POS        5'h1f  // no data bit to flip
`define CSI2_SHORT_ID_MAX  8'h0F

// crc-16, reflected ccitt, lsb first
`define CSI2_CRC_INIT      16'hFFFF
`define CSI2_CRC_POLY      16'h8408

`define CSI2_DROP_W        8

`endif

// File: rtl/csi2_rx_pkg.sv
`include "csi2_rx_consts.svh"

package csi2_rx_pkg;

  typedef logic [31:0]              word_t;
  typedef logic [7:0]               data_id_t;
  typedef logic [15:0]              wcount_t;
  typedef logic [5:0]               ecc_t;      // ecc value or syndrome
  typedef logic [4:0]               bitpos_t;
  typedef logic [15:0]              crc_t;
  typedef logic [`CSI2_DROP_W-1:0]  drop_cnt_t;

  typedef enum logic [2:0] {IDLE, PAYLOAD, CRC_WAIT, REPORT, DROP} ctrl_state_t;

  // syndrome equal to an ecc column points at that data bit
  function automatic bitpos_t syndrome_pos(ecc_t syn);
    bitpos_t pos;
    case (syn)
      6'h07: pos = 5'd0;
      6'h0B: pos = 5'd1;
      6'h0D: pos = 5'd2;
      6'h0E: pos = 5'd3;
      6'h13: pos = 5'd4;
      6'h15: pos = 5'd5;
      6'h16: pos = 5'd6;
      6'h19: pos = 5'd7;
      6'h1A: pos = 5'd8;
      6'h1C: pos = 5'd9;
      6'h23: pos = 5'd10;
      6'h25: pos = 5'd11;
      6'h26: pos = 5'd12;
      6'h29: pos = 5'd13;
      6'h2A: pos = 5'd14;
      6'h2C: pos = 5'd15;
      6'h31: pos = 5'd16;
      6'h32: pos = 5'd17;
      6'h34: pos = 5'd18;
      6'h38: pos = 5'd19;
      6'h1F: pos = 5'd20;
      6'h2F: pos = 5'd21;
      6'h37: pos = 5'd22;
      6'h3B: pos = 5'd23;
      default: pos = `CSI2_NO_POS;  // ecc bit error or uncorrectable
    endcase
    return pos;
  endfunction

endpackage

// File: rtl/csi2_rx_top.sv
module csi2_rx_top
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   in_valid_i,
  input  csi2_rx_pkg::word_t     in_data_i,
  input  logic                   sts_ack_i,
  output logic                   pld_valid_o,
  output csi2_rx_pkg::word_t     pld_data_o,
  output logic                   pld_last_o,
  output logic                   sts_req_o,
  output csi2_rx_pkg::data_id_t  sts_data_id_o,
  output csi2_rx_pkg::wcount_t   sts_wcount_o,
  output logic                   sts_ecc_err_o,
  output logic                   sts_ecc_corr_o,
  output logic                   sts_crc_err_o,
  output csi2_rx_pkg::drop_cnt_t sts_drop_o
);

  import csi2_rx_pkg::*;

  // decoder to control
  logic     hd_valid;
  word_t    hd_data;
  logic     hd_err;
  logic     hd_corr;
  logic     pkt_done;

  // control to crc checker
  logic     crc_start;
  logic     crc_word_valid;
  word_t    crc_word;
  logic     crc_check;
  crc_t     crc_rx;
  logic     crc_err;

  // control to status port
  logic     rec_valid;
  data_id_t rec_data_id;
  wcount_t  rec_wcount;
  logic     rec_ecc_err;
  logic     rec_ecc_corr;
  logic     rec_crc_err;

  csi2_hamming_dec u_dec
  (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .valid_i           (in_valid_i),
    .data_i            (in_data_i),
    .pkt_done_i        (pkt_done),
    .valid_o           (hd_valid),
    .data_o            (hd_data),
    .error_o           (hd_err),
    .error_corrected_o (hd_corr)
  );

  csi2_pkt_ctrl u_ctrl
  (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .hd_valid_i       (hd_valid),
    .hd_data_i        (hd_data),
    .hd_err_i         (hd_err),
    .hd_corr_i        (hd_corr),
    .crc_err_i        (crc_err),
    .pkt_done_o       (pkt_done),
    .crc_start_o      (crc_start),
    .crc_word_valid_o (crc_word_valid),
    .crc_word_o       (crc_word),
    .crc_check_o      (crc_check),
    .crc_rx_o         (crc_rx),
    .pld_valid_o      (pld_valid_o),
    .pld_data_o       (pld_data_o),
    .pld_last_o       (pld_last_o),
    .rec_valid_o      (rec_valid),
    .rec_data_id_o    (rec_data_id),
    .rec_wcount_o     (rec_wcount),
    .rec_ecc_err_o    (rec_ecc_err),
    .rec_ecc_corr_o   (rec_ecc_corr),
    .rec_crc_err_o    (rec_crc_err)
  );

  csi2_crc16_chk u_crc
  (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .start_i      (crc_start),
    .word_valid_i (crc_word_valid),
    .word_i       (crc_word),
    .check_i      (crc_check),
    .crc_rx_i     (crc_rx),
    .crc_err_o    (crc_err)
  );

  csi2_sts_port u_sts
  (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .rec_valid_i    (rec_valid),
    .rec_data_id_i  (rec_data_id),
    .rec_wcount_i   (rec_wcount),
    .rec_ecc_err_i  (rec_ecc_err),
    .rec_ecc_corr_i (rec_ecc_corr),
    .rec_crc_err_i  (rec_crc_err),
    .sts_ack_i      (sts_ack_i),
    .sts_req_o      (sts_req_o),
    .sts_data_id_o  (sts_data_id_o),
    .sts_wcount_o   (sts_wcount_o),
    .sts_ecc_err_o  (sts_ecc_err_o),
    .sts_ecc_corr_o (sts_ecc_corr_o),
    .sts_crc_err_o  (sts_crc_err_o),
    .sts_drop_o     (sts_drop_o)
  );

endmodule

// File: rtl/csi2_sts_port.sv
module csi2_sts_port
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   rec_valid_i,
  input  csi2_rx_pkg::data_id_t  rec_data_id_i,
  input  csi2_rx_pkg::wcount_t   rec_wcount_i,
  input  logic                   rec_ecc_err_i,
  input  logic                   rec_ecc_corr_i,
  input  logic                   rec_crc_err_i,
  input  logic                   sts_ack_i,
  output logic                   sts_req_o,
  output csi2_rx_pkg::data_id_t  sts_data_id_o,
  output csi2_rx_pkg::wcount_t   sts_wcount_o,
  output logic                   sts_ecc_err_o,
  output logic                   sts_ecc_corr_o,
  output logic                   sts_crc_err_o,
  output csi2_rx_pkg::drop_cnt_t sts_drop_o
);

  import csi2_rx_pkg::*;

  logic port_free;   // req and ack both low
  logic rec_take;

  assign port_free = !sts_req_o && !sts_ack_i;
  assign rec_take  = rec_valid_i && port_free;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      sts_req_o  <= 1'b0;
      sts_drop_o <= '0;
    end
    else
    begin
      if (rec_take)
        sts_req_o <= 1'b1;
      else if (sts_req_o && sts_ack_i)
        sts_req_o <= 1'b0;                     // phase 3, wait for ack low
      if (rec_valid_i && !port_free && (sts_drop_o != '1))
        sts_drop_o <= sts_drop_o + drop_cnt_t'(1);
    end
  end

  // fields frozen while req is up
  always_ff @(posedge clk_i)
  begin
    if (rec_take)
    begin
      sts_data_id_o  <= rec_data_id_i;
      sts_wcount_o   <= rec_wcount_i;
      sts_ecc_err_o  <= rec_ecc_err_i;
      sts_ecc_corr_o <= rec_ecc_corr_i;
      sts_crc_err_o  <= rec_crc_err_i;
    end
  end

endmodule

// File: test/csi2_rx_assert.sv
module csi2_rx_assert
(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  req_i,
  input logic                  ack_i,
  input csi2_rx_pkg::data_id_t data_id_i,
  input csi2_rx_pkg::wcount_t  wcount_i,
  input logic                  ecc_err_i,
  input logic                  ecc_corr_i,
  input logic                  crc_err_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_errs = 0;   // read by the testbench at the end

  // phase 1 to 2, req waits for the receiver
  req_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
                                  (req_i && !ack_i) |=> req_i)
  else
  begin
    $error("sts_req_o dropped before sts_ack_i was raised");
    assert_errs++;
  end

  // no new record until ack is back low
  no_req_on_ack: assert property (@(posedge clk_i) disable iff (rst_i)
                                  (!req_i && ack_i) |=> !req_i)
  else
  begin
    $error("sts_req_o raised while sts_ack_i was still high");
    assert_errs++;
  end

  fields_stable: assert property (@(posedge clk_i) disable iff (rst_i)
                                  (req_i && $past(req_i)) |->
                                  $stable({data_id_i, wcount_i, ecc_err_i, ecc_corr_i, crc_err_i}))
  else
  begin
    $error("status fields changed while sts_req_o was high");
    assert_errs++;
  end

endmodule

// File: test/tb_csi2_rx.sv
`include "csi2_rx_consts.svh"

module tb_csi2_rx;

  timeunit 1ns;
  timeprecision 1ps;

  import csi2_rx_pkg::*;

  localparam int NUM_PKT    = 200;
  localparam int DROP_FIRST = 100;   // first packet with ack withheld
  localparam int DROP_PKTS  = 3;
  localparam int CLK_PERIOD = 100;
  localparam int WD_CYCLES  = NUM_PKT * 40;

  // csi-2 ecc columns, data bit 23 leftmost
  localparam logic [23:0][5:0] ECC_COL = {6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34,
                                          6'h32, 6'h31, 6'h2C, 6'h2A, 6'h29, 6'h26,
                                          6'h25, 6'h23, 6'h1C, 6'h1A, 6'h19, 6'h16,
                                          6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07};

  logic      clk_i;
  logic      rst_i;
  logic      in_valid_i;
  word_t     in_data_i;
  logic      sts_ack_i;
  logic      pld_valid_o;
  word_t     pld_data_o;
  logic      pld_last_o;
  logic      sts_req_o;
  data_id_t  sts_data_id_o;
  wcount_t   sts_wcount_o;
  logic      sts_ecc_err_o;
  logic      sts_ecc_corr_o;
  logic      sts_crc_err_o;
  drop_cnt_t sts_drop_o;

  logic [32:0] exp_pld[$];   // {last, data}
  logic [26:0] exp_rec[$];   // {id, wcount, ecc_err, ecc_corr, crc_err}
  int          pld_errs   = 0;
  int          rec_errs   = 0;
  int          misc_errs  = 0;
  int          rec_pushed = 0;
  int          rec_done   = 0;
  int          exp_drops  = 0;
  int          ack_wait   = 0;
  logic        hold_ack   = 1'b0;

  csi2_rx_top UUT
  (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .in_valid_i     (in_valid_i),
    .in_data_i      (in_data_i),
    .sts_ack_i      (sts_ack_i),
    .pld_valid_o    (pld_valid_o),
    .pld_data_o     (pld_data_o),
    .pld_last_o     (pld_last_o),
    .sts_req_o      (sts_req_o),
    .sts_data_id_o  (sts_data_id_o),
    .sts_wcount_o   (sts_wcount_o),
    .sts_ecc_err_o  (sts_ecc_err_o),
    .sts_ecc_corr_o (sts_ecc_corr_o),
    .sts_crc_err_o  (sts_crc_err_o),
    .sts_drop_o     (sts_drop_o)
  );

  bind csi2_sts_port csi2_rx_assert u_assert
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (sts_req_o),
    .ack_i      (sts_ack_i),
    .data_id_i  (sts_data_id_o),
    .wcount_i   (sts_wcount_o),
    .ecc_err_i  (sts_ecc_err_o),
    .ecc_corr_i (sts_ecc_corr_o),
    .crc_err_i  (sts_crc_err_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic ecc_t ecc_of(logic [23:0] d);
    ecc_t e;
    e = '0;
    for (int i = 0; i < 24; i++)
      if (d[i])
        e = e ^ ECC_COL[i];
    return e;
  endfunction

  // serial crc, word bit 0 first
  function automatic crc_t crc_update(crc_t crc, word_t w);
    crc_t c;
    logic fb;
    c = crc;
    for (int i = 0; i < 32; i++)
    begin
      fb = c[0] ^ w[i];
      c  = c >> 1;
      if (fb)
        c = c ^ `CSI2_CRC_POLY;
    end
    return c;
  endfunction

  task automatic drive_word(input word_t w);
    @(posedge clk_i);
    in_valid_i <= 1'b1;
    in_data_i  <= w;
  endtask

  task automatic drive_idle(input int n);
    repeat (n)
    begin
      @(posedge clk_i);
      in_valid_i <= 1'b0;
      in_data_i  <= $urandom;       // junk between packets
    end
  endtask

  task automatic wait_records();
    while (rec_done != rec_pushed)
      @(posedge clk_i);
  endtask

  task automatic send_packet(input bit keep_rec);
    data_id_t id;
    wcount_t  wc;
    bit       is_short;
    int       n_words;
    int       n_flip;
    int       r;
    int       p1;
    int       p2;
    word_t    hdr_tx;
    word_t    pld[$];
    word_t    crc_word;
    crc_t     crc;
    crc_t     crc_tx;
    is_short = ($urandom_range(0, 3) == 0);
    if (is_short)
    begin
      id = data_id_t'($urandom_range(0, 15));
      wc = wcount_t'($urandom);
    end
    else
    begin
      id = data_id_t'($urandom_range(16, 255));
      wc = wcount_t'($urandom_range(0, 64));
    end
    n_words = is_short ? 0 : int'(wc >> 2);
    hdr_tx  = {2'b00, ecc_of({wc, id}), wc, id};
    r       = $urandom_range(0, 9);
    n_flip  = (r < 6) ? 0 : ((r < 8) ? 1 : 2);
    p1      = $urandom_range(0, 29);
    p2      = $urandom_range(0, 28);
    if (p2 >= p1)
      p2++;                          // two distinct bits
    if (n_flip > 0)
      hdr_tx[p1] = ~hdr_tx[p1];
    if (n_flip > 1)
      hdr_tx[p2] = ~hdr_tx[p2];

    crc = `CSI2_CRC_INIT;
    for (int i = 0; i < n_words; i++)
    begin
      pld.push_back($urandom);
      crc = crc_update(crc, pld[i]);
    end
    crc_tx = crc;
    if ($urandom_range(0, 7) == 0)
      crc_tx = crc ^ crc_t'(1 << $urandom_range(0, 15));
    crc_word        = $urandom;
    crc_word[15:0]  = crc_tx;

    if (keep_rec)
    begin
      if (n_flip == 2)               // uncorrected header is reported as seen
        exp_rec.push_back({hdr_tx[7:0], hdr_tx[23:8], 1'b1, 1'b0, 1'b0});
      else
        exp_rec.push_back({id, wc, n_flip == 1, n_flip == 1, !is_short && (crc_tx != crc)});
      rec_pushed++;
    end
    else
      exp_drops++;
    if (n_flip != 2)
      foreach (pld[i])
        exp_pld.push_back({i == n_words - 1, pld[i]});

    drive_word(hdr_tx);
    if (!is_short)
    begin
      foreach (pld[i])
        drive_word(pld[i]);
      drive_word(crc_word);
    end
  endtask

  // --------------------------------------------------------------------------
  // checkers and ack responder
  // --------------------------------------------------------------------------
  always @(posedge clk_i)
  begin
    logic [32:0] exp_word;
    if (!rst_i && pld_valid_o)
    begin
      assert (exp_pld.size() > 0)
      else
      begin
        $display("payload word %h delivered with none expected at %0t", pld_data_o, $time);
        pld_errs++;
      end
      if (exp_pld.size() > 0)
      begin
        exp_word = exp_pld.pop_front();
        assert ({pld_last_o, pld_data_o} == exp_word)
        else
        begin
          $display("ERROR %0t: payload %h last %b, expected %h last %b", $time,
                   pld_data_o, pld_last_o, exp_word[31:0], exp_word[32]);
          pld_errs++;
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    logic [26:0] rec;
    if (rst_i)
    begin
      sts_ack_i <= 1'b0;
      ack_wait  <= $urandom_range(0, 4);
    end
    else if (sts_req_o && !sts_ack_i && !hold_ack)
    begin
      if (ack_wait > 0)
        ack_wait <= ack_wait - 1;
      else
      begin
        sts_ack_i <= 1'b1;
        assert (exp_rec.size() > 0)
        else
        begin
          $display("status record raised with no packet behind it at %0t", $time);
          rec_errs++;
        end
        if (exp_rec.size() > 0)
        begin
          rec = exp_rec.pop_front();
          assert ({sts_data_id_o, sts_wcount_o, sts_ecc_err_o, sts_ecc_corr_o,
                   sts_crc_err_o} == rec)
          else
          begin
            $display("ERROR %0t: record id %h wc %h flags %b%b%b, expected id %h wc %h flags %b",
                     $time, sts_data_id_o, sts_wcount_o, sts_ecc_err_o, sts_ecc_corr_o,
                     sts_crc_err_o, rec[26:19], rec[18:3], rec[2:0]);
            rec_errs++;
          end
        end
      end
    end
    else if (!sts_req_o && sts_ack_i)
    begin
      sts_ack_i <= 1'b0;              // phase 4
      ack_wait  <= $urandom_range(0, 4);
      rec_done  <= rec_done + 1;
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    int total;
    void'($urandom(32'h74f8_1e5b));
    rst_i      = 1'b1;
    in_valid_i = 1'b0;
    in_data_i  = '0;
    sts_ack_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    assert (!pld_valid_o && !pld_last_o && !sts_req_o && sts_drop_o == '0)
    else
    begin
      $display("ERROR %0t: outputs not idle after reset", $time);
      misc_errs++;
    end
    drive_idle(3);

    for (int n = 0; n < NUM_PKT; n++)
    begin
      if (n >= DROP_FIRST && n < DROP_FIRST + DROP_PKTS)
      begin
        if (n == DROP_FIRST)
          hold_ack <= 1'b1;          // first record stalls the port
        send_packet(n == DROP_FIRST);
        drive_idle(8);
        if (n == DROP_FIRST + DROP_PKTS - 1)
        begin
          assert (sts_drop_o == drop_cnt_t'(exp_drops))
          else
          begin
            $display("ERROR %0t: drop count %0d, expected %0d", $time, sts_drop_o, exp_drops);
            misc_errs++;
          end
          hold_ack <= 1'b0;
          wait_records();
        end
      end
      else
      begin
        send_packet(1'b1);
        drive_idle($urandom_range(3, 6));
        wait_records();
      end
    end

    drive_idle(10);
    assert (exp_pld.size() == 0)
    else
    begin
      $display("%0d payload words never delivered", exp_pld.size());
      misc_errs++;
    end
    assert (exp_rec.size() == 0)
    else
    begin
      $display("%0d status records never raised", exp_rec.size());
      misc_errs++;
    end
    assert (sts_drop_o == drop_cnt_t'(exp_drops))
    else
    begin
      $display("ERROR %0t: final drop count %0d, expected %0d", $time, sts_drop_o, exp_drops);
      misc_errs++;
    end

    total = pld_errs + rec_errs + misc_errs + int'(UUT.u_sts.u_assert.assert_errs);
    $display("errors: payload %0d  record %0d  other %0d  assertion %0d", pld_errs,
             rec_errs, misc_errs, UUT.u_sts.u_assert.assert_errs);
    if (total == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // watchdog sized on the worst packet length
  initial
  begin
    #(CLK_PERIOD * WD_CYCLES);
    $display("timeout: run did not finish within %0d clock cycles", WD_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

endmodule
